// ==== Bender.yml ====
package:
  name: sram_fifo

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/fifo_pkg.sv
      - hw/sram_if.sv
      - hw/fifo_ctrl.sv
      - hw/sp_sram.sv
      - hw/sram_fifo.sv
  - target: test
    include_dirs:
      - hw
    files:
      - verification/sram_fifo_tb.sv

// ==== build.f ====
+incdir+hw
hw/fifo_pkg.sv
hw/sram_if.sv
hw/fifo_ctrl.sv
hw/sp_sram.sv
hw/sram_fifo.sv
verification/sram_fifo_tb.sv

// ==== hw/fifo_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "fifo_macros.svh"

module fifo_ctrl (
  input  wire                  clk,
  input  wire                  rst_n,
  input  wire                  push,
  input  wire fifo_pkg::data_t push_data,
  input  wire                  pop,
  output fifo_pkg::data_t      pop_data,
  output logic                 pop_valid,
  output logic                 empty,
  output logic                 almost_empty,
  output logic                 almost_full,
  output logic                 full,
  output logic                 error,
  sram_if.ctrl                 mem
);

  fifo_pkg::ctrl_state_t state;
  fifo_pkg::ctrl_state_t state_next;
  fifo_pkg::ptr_t        head;       // next slot to write.
  fifo_pkg::ptr_t        head_next;
  fifo_pkg::ptr_t        tail;       // oldest stored word.
  fifo_pkg::ptr_t        tail_next;
  fifo_pkg::ptr_t        fill;       // entries held, modulo depth.
  logic                  head_plus;
  logic                  tail_plus;
  logic                  do_push;
  logic                  do_pop;
  logic                  req_bad;
  logic                  last_word;
  logic                  one_free;

  // distance between the pointers.
  // in empty and full both sit on the same slot, so the state decides.
  assign fill      = head - tail;
  assign last_word = (fill == fifo_pkg::ptr_t'(1));
  assign one_free  = (fill == fifo_pkg::ptr_t'(`FIFO_DEPTH - 1));

  // a request is taken only when it is alone and the state allows it.
  always_comb begin
    do_push = 1'b0;
    do_pop  = 1'b0;
    case (state)
      fifo_pkg::st_empty: begin
        do_push = push && !pop;
      end
      fifo_pkg::st_between: begin
        do_push = push && !pop;
        do_pop  = pop && !push;
      end
      fifo_pkg::st_full: begin
        do_pop = pop && !push;
      end
      default: begin
        do_push = 1'b0;  // readout takes nothing.
      end
    endcase
  end

  assign req_bad = (push || pop) && !(do_push || do_pop);

  // sram strobes and pointer steps.
  always_comb begin
    mem.cen   = 1'b1;
    mem.wen   = 1'b1;
    mem.oen   = 1'b1;
    mem.addr  = tail;
    head_plus = 1'b0;
    tail_plus = 1'b0;
    if (do_push) begin
      mem.cen   = 1'b0;
      mem.wen   = 1'b0;
      mem.addr  = head;
      head_plus = 1'b1;
    end
    if (do_pop) begin
      mem.cen = 1'b0;  // read at tail into the sram output register.
    end
    if (state == fifo_pkg::st_readout) begin
      mem.oen   = 1'b0;
      tail_plus = 1'b1;
    end
  end

  assign mem.wdata = push_data;

  // next state.
  always_comb begin
    state_next = state;
    case (state)
      fifo_pkg::st_empty: begin
        if (do_push) begin
          state_next = fifo_pkg::st_between;
        end
      end
      fifo_pkg::st_between: begin
        if (do_push && one_free) begin
          state_next = fifo_pkg::st_full;  // head catches up with tail.
        end else if (do_pop) begin
          state_next = fifo_pkg::st_readout;
        end
      end
      fifo_pkg::st_readout: begin
        if (last_word) begin
          state_next = fifo_pkg::st_empty;
        end else begin
          state_next = fifo_pkg::st_between;
        end
      end
      fifo_pkg::st_full: begin
        if (do_pop) begin
          state_next = fifo_pkg::st_readout;
        end
      end
      default: begin
        state_next = fifo_pkg::st_empty;
      end
    endcase
  end

  assign head_next = head_plus ? head + fifo_pkg::ptr_t'(1) : head;
  assign tail_next = tail_plus ? tail + fifo_pkg::ptr_t'(1) : tail;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= fifo_pkg::st_empty;
      head      <= '0;
      tail      <= '0;
      pop_valid <= 1'b0;
      error     <= 1'b0;
    end else begin
      state     <= state_next;
      head      <= head_next;
      tail      <= tail_next;
      pop_valid <= (state == fifo_pkg::st_readout);
      error     <= req_bad;  // one cycle per rejected request.
    end
  end

  always_ff @(posedge clk) begin
    if (state == fifo_pkg::st_readout) begin
      pop_data <= mem.rdata;
    end
  end

  // status flags.
  assign empty        = (state == fifo_pkg::st_empty);
  assign full         = (state == fifo_pkg::st_full);
  assign almost_empty = (state == fifo_pkg::st_between) && last_word;
  assign almost_full  = (state == fifo_pkg::st_between) && one_free;

endmodule

`default_nettype wire

// ==== hw/fifo_macros.svh ====
`ifndef FIFO_MACROS_SVH
`define FIFO_MACROS_SVH

// number of fifo entries held in the sram.
`define FIFO_DEPTH  64

// head, tail and sram address width.
`define FIFO_ADDR_W 6

// width of one stored word.
`define FIFO_DATA_W 16

`endif

// ==== hw/fifo_pkg.sv ====
`default_nettype none
`include "fifo_macros.svh"

package fifo_pkg;

  // pointer into the sram that wraps at the depth.
  typedef logic [`FIFO_ADDR_W-1:0] ptr_t;

  // one fifo word.
  typedef logic [`FIFO_DATA_W-1:0] data_t;

  // controller states.
  typedef enum logic [1:0] {
    st_empty   = 2'b00,
    st_between = 2'b01,
    st_readout = 2'b10,  // sram word is on rdata.
    st_full    = 2'b11
  } ctrl_state_t;

endpackage

`default_nettype wire

// ==== hw/sp_sram.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "fifo_macros.svh"

module sp_sram (
  input wire  clk,
  input wire  rst_n,
  sram_if.mem mem
);

  fifo_pkg::data_t ram [`FIFO_DEPTH];
  fifo_pkg::data_t rd_q;  // read port register.
  logic            wr_en;
  logic            rd_en;

  assign wr_en = !mem.cen && !mem.wen;
  assign rd_en = !mem.cen && mem.wen;

  // write port.
  always_ff @(posedge clk) begin
    if (wr_en) begin
      ram[mem.addr] <= mem.wdata;
    end
  end

  // the read word shows one edge after the strobe.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_q <= '0;
    end else if (rd_en) begin
      rd_q <= ram[mem.addr];
    end
  end

  assign mem.rdata = mem.oen ? '0 : rd_q;  // driver off reads as zero.

endmodule

`default_nettype wire

// ==== hw/sram_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module sram_fifo (
  input  wire                  clk,
  input  wire                  rst_n,
  input  wire                  push,
  input  wire fifo_pkg::data_t push_data,
  input  wire                  pop,
  output wire fifo_pkg::data_t pop_data,
  output wire                  pop_valid,
  output wire                  empty,
  output wire                  almost_empty,
  output wire                  almost_full,
  output wire                  full,
  output wire                  error
);

  // strobes, address and data between controller and memory.
  sram_if sram_bus ();

  fifo_ctrl fifo_ctrl_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .push         (push),
    .push_data    (push_data),
    .pop          (pop),
    .pop_data     (pop_data),
    .pop_valid    (pop_valid),
    .empty        (empty),
    .almost_empty (almost_empty),
    .almost_full  (almost_full),
    .full         (full),
    .error        (error),
    .mem          (sram_bus)
  );

  // one word per fifo slot.
  sp_sram sp_sram_inst (
    .clk   (clk),
    .rst_n (rst_n),
    .mem   (sram_bus)
  );

endmodule

`default_nettype wire

// ==== hw/sram_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface sram_if;

  logic            cen;    // active low chip enable.
  logic            wen;    // active low write enable.
  logic            oen;    // active low output enable.
  fifo_pkg::ptr_t  addr;
  fifo_pkg::data_t wdata;
  fifo_pkg::data_t rdata;  // zero while oen is high.

  modport ctrl (
    output cen,
    output wen,
    output oen,
    output addr,
    output wdata,
    input  rdata
  );

  modport mem (
    input  cen,
    input  wen,
    input  oen,
    input  addr,
    input  wdata,
    output rdata
  );

endinterface

`default_nettype wire

// ==== verification/sram_fifo_tb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "fifo_macros.svh"

module sram_fifo_tb;

  logic            clk;
  logic            rst_n;
  logic            push;
  fifo_pkg::data_t push_data;
  logic            pop;
  fifo_pkg::data_t pop_data;
  logic            pop_valid;
  logic            empty;
  logic            almost_empty;
  logic            almost_full;
  logic            full;
  logic            error;

  fifo_pkg::data_t model_q[$];  // words the fifo should hold in arrival order.
  int              error_count;
  int              pass_count;
  int              fail_count;
  int              test_start_errors;
  string           test_name;

  sram_fifo sram_fifo_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .push         (push),
    .push_data    (push_data),
    .pop          (pop),
    .pop_data     (pop_data),
    .pop_valid    (pop_valid),
    .empty        (empty),
    .almost_empty (almost_empty),
    .almost_full  (almost_full),
    .full         (full),
    .error        (error)
  );

  always #20 clk = ~clk;

  // flag order is empty, almost_empty, almost_full, full.
  function automatic logic [3:0] expected_flags(input int size);
    expected_flags = {size == 0, size == 1, size == `FIFO_DEPTH - 1, size == `FIFO_DEPTH};
  endfunction

  // busy means the request lands while a pop is being read out.
  function automatic logic expected_error(input logic p, input logic q, input int size,
                                          input logic busy);
    if (busy) begin
      return p || q;
    end else if (p && q) begin
      return 1'b1;
    end else if (p) begin
      return size == `FIFO_DEPTH;
    end else if (q) begin
      return size == 0;
    end
    return 1'b0;
  endfunction

  task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                       input string msg);
    if (actual !== expected) begin
      $display("FAILED at %0t ns: %s (got %0h, expected %0h)", $time, msg, actual, expected);
      error_count++;
    end
  endtask

  task automatic step();
    @(posedge clk);
    #2;  // outputs have settled and inputs may change.
  endtask

  task automatic check_flags(input string msg);
    check({empty, almost_empty, almost_full, full}, expected_flags(model_q.size()), msg);
  endtask

  task automatic start_test(input string name);
    test_name         = name;
    test_start_errors = error_count;
  endtask

  task automatic finish_test();
    if (error_count == test_start_errors) begin
      pass_count++;
      $display("test %s: ok", test_name);
    end else begin
      fail_count++;
      $display("test %s: %0d mismatches", test_name, error_count - test_start_errors);
    end
  endtask

  task automatic wait_pop_valid(output logic seen, output int waited);
    int i;
    i = 0;
    while (!pop_valid && i < 20) begin
      step();
      i++;
    end
    seen   = pop_valid;
    waited = i;
    if (!seen) begin
      $display("timeout waiting for pop_valid at %0t ns", $time);
      error_count++;
    end
  endtask

  task automatic push_word(input fifo_pkg::data_t d);
    logic exp_err;
    exp_err   = expected_error(1'b1, 1'b0, model_q.size(), 1'b0);
    push      = 1'b1;
    push_data = d;
    step();
    push = 1'b0;
    if (!exp_err) begin
      model_q.push_back(d);
    end
    check(error, exp_err, "error flag after push");
    check(pop_valid, 1'b0, "pop_valid after push");
    check_flags("flags after push");
    if (exp_err) begin
      step();
      check(error, 1'b0, "error pulse longer than one cycle");
      check_flags("flags after rejected push");
    end
  endtask

  task automatic pop_word();
    logic            exp_err;
    logic            seen;
    int              waited;
    fifo_pkg::data_t exp_data;
    exp_err = expected_error(1'b0, 1'b1, model_q.size(), 1'b0);
    pop     = 1'b1;
    step();
    pop = 1'b0;
    check(error, exp_err, "error flag after pop");
    check(pop_valid, 1'b0, "pop_valid in the cycle after pop");
    if (exp_err) begin
      check_flags("flags after rejected pop");
      repeat (2) begin
        step();
        check(pop_valid, 1'b0, "pop_valid after rejected pop");
        check(error, 1'b0, "error pulse longer than one cycle");
      end
    end else begin
      exp_data = model_q.pop_front();
      wait_pop_valid(seen, waited);
      if (seen) begin
        check(waited, 1, "pop_valid latency");
        check(pop_data, exp_data, "pop_data out of order");
        check(error, 1'b0, "error during pop");
        check_flags("flags after pop");
      end
    end
  endtask

  task automatic push_and_pop(input fifo_pkg::data_t d);
    logic exp_err;
    exp_err   = expected_error(1'b1, 1'b1, model_q.size(), 1'b0);
    push      = 1'b1;
    pop       = 1'b1;
    push_data = d;
    step();
    push = 1'b0;
    pop  = 1'b0;
    check(error, exp_err, "error on push and pop together");
    check_flags("flags after push and pop together");
    step();
    check(pop_valid, 1'b0, "pop_valid after rejected push and pop");
    check(error, 1'b0, "error pulse longer than one cycle");
    check_flags("flags after push and pop together");
  endtask

  task automatic push_in_readout(input fifo_pkg::data_t d);
    logic            exp_err;
    logic            seen;
    int              waited;
    fifo_pkg::data_t exp_data;
    pop = 1'b1;
    step();
    pop = 1'b0;
    check(error, 1'b0, "error after legal pop");
    exp_err   = expected_error(1'b1, 1'b0, model_q.size(), 1'b1);
    exp_data  = model_q.pop_front();
    push      = 1'b1;  // lands in the readout cycle.
    push_data = d;
    step();
    push = 1'b0;
    check(error, exp_err, "error on push during readout");
    wait_pop_valid(seen, waited);
    if (seen) begin
      check(waited, 0, "pop_valid latency with push during readout");
      check(pop_data, exp_data, "pop_data with push during readout");
      check_flags("flags after pop with push during readout");
    end
    step();
    check(error, 1'b0, "error pulse longer than one cycle");
    check_flags("flags after push during readout");
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      step();
      check(error, 1'b0, "error while idle");
      check(pop_valid, 1'b0, "pop_valid while idle");
      check_flags("flags while idle");
    end
  endtask

  initial begin
    int unsigned sel;
    int          i;
    clk               = 1'b0;
    rst_n             = 1'b0;
    push              = 1'b0;
    pop               = 1'b0;
    push_data         = '0;
    error_count       = 0;
    pass_count        = 0;
    fail_count        = 0;
    test_start_errors = 0;
    void'($urandom(25663));
    repeat (8) @(posedge clk);
    #2 rst_n = 1'b1;

    start_test("reset");
    check(error, 1'b0, "error after reset");
    check(pop_valid, 1'b0, "pop_valid after reset");
    check_flags("flags after reset");
    finish_test();

    start_test("fill");
    repeat (`FIFO_DEPTH) push_word(fifo_pkg::data_t'($urandom));
    push_word(fifo_pkg::data_t'($urandom));  // one past full.
    finish_test();

    start_test("drain");
    repeat (`FIFO_DEPTH) pop_word();
    pop_word();  // underflow.
    finish_test();

    start_test("illegal");
    repeat (3) push_word(fifo_pkg::data_t'($urandom));
    push_and_pop(fifo_pkg::data_t'($urandom));
    push_in_readout(fifo_pkg::data_t'($urandom));
    while (model_q.size() > 0) begin
      pop_word();
    end
    idle_cycles(2);  // a stray stored word would leave empty low.
    finish_test();

    start_test("random");
    for (i = 0; i < 400; i++) begin
      sel = $urandom_range(0, 19);
      if (sel < 9) begin
        push_word(fifo_pkg::data_t'($urandom));
      end else if (sel < 18) begin
        pop_word();
      end else begin
        idle_cycles(1 + $urandom_range(0, 2));
      end
    end
    finish_test();

    $display("summary: %0d passed, %0d failed, %0d mismatches",
             pass_count, fail_count, error_count);
    if (fail_count == 0 && error_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
